//--- dv/vsi_stim.txt
// Columns: op (0 configure, 1 start, 2 stop, 3 update), period, duty 0 to 3,
// update mask, stall flag (1 for random back-pressure); all values hex
0 0000 0000 0000 0000 0000 0 0
3 03E8 0064 01F4 0320 0000 1 0
3 03E7 0065 03E7 0001 0002 8 1
1 0000 0000 0000 0000 0000 0 0
3 0800 0100 0200 0300 0400 2 1  // held while the modulator runs
3 0900 0110 0210 0310 0410 4 0
2 0FA0 07D0 0010 0F00 0123 0 1  // burst carries these values
0 0000 0000 0000 0000 0000 0 1
3 0002 0005 0003 FFFF 0000 F 1  // rise wraps below zero
3 1234 0011 0022 0033 0044 0 0  // empty mask writes nothing
1 0000 0000 0000 0000 0000 0 1
2 0000 0000 0000 0000 0000 0 1

//--- vsi_pre_modulation_processor.f
verilog/vsi_modulation_pkg.sv
verilog/compare_calculator.sv
verilog/modulator_sequencer.sv
verilog/register_writer.sv
verilog/vsi_pre_modulation_processor.sv
dv/write_monitor.sv
dv/vsi_pre_modulation_processor_chk.sv
dv/tb_vsi_pre_modulation_processor.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_vsi_pre_modulation_processor -f vsi_pre_modulation_processor.f \
    && ./obj_dir/Vtb_vsi_pre_modulation_processor > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation PASSED$" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- dv/tb_vsi_pre_modulation_processor.sv
//--------------------------------------------------
// Testbench for the VSI pre-modulation processor
// Replays the operation list, models the PWM write
// slave and predicts every register write
//--------------------------------------------------
`timescale 1ns/1ps

module tb_vsi_pre_modulation_processor;
    import vsi_modulation_pkg::*;

    localparam int max_lines = 32;
    localparam int line_words = 8;
    localparam logic [31:0] base_addr = 32'h43C0_0000;

    logic clock;
    logic reset;
    logic configure;
    logic start;
    logic stop;
    logic [3:0] update;
    logic [15:0] period;
    logic [3:0][15:0] duty;
    logic write_ready;
    logic write_valid;
    write_req_t write_req;
    logic done;
    logic modulator_status;

    logic [15:0] stim_mem [max_lines * line_words];
    logic [31:0] rng_state = 32'h0f88_4b54;
    int line_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    logic stall_enable = 1'b0;
    logic model_status = 1'b0;
    logic update_waiting = 1'b0;

    vsi_pre_modulation_processor DUT (.*);

    write_monitor monitor (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state ^ (state << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // PWM slave: drops ready after each write, longer when the line asks for stalls
    initial begin
        int low_cycles;
        write_ready = 1'b1;
        forever begin
            @(posedge clock);
            if (write_valid) begin
                rng_state = xorshift32(rng_state);
                low_cycles = stall_enable ? int'(rng_state[2:0]) + 1 : 1;
                #1 write_ready = 1'b0;
                repeat (low_cycles) @(posedge clock);
                #1 write_ready = 1'b1;
            end
        end
    end

    task automatic step_cycle();
        @(posedge clock);
        #1;
    endtask

    // Center-aligned compares, each half truncated on its own
    task automatic expect_compare_burst(input logic [15:0] p, input logic [3:0][15:0] d);
        logic [15:0] half_period;
        logic [15:0] half_duty;
        half_period = p >> 1;
        monitor.expect_write(base_addr + 32'h134, {16'h0000, p}, 1'b0);
        for (int k = 0; k < 4; k++) begin
            half_duty = d[k] >> 1;
            monitor.expect_write(base_addr + 32'h100 + 32'(4 * k),
                {16'h0000, half_period - half_duty}, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            half_duty = d[k] >> 1;
            monitor.expect_write(base_addr + 32'h110 + 32'(4 * k),
                {16'h0000, half_period + half_duty}, 1'b0);
        end
    endtask

    function automatic string op_name(input logic [15:0] op);
        case (op)
            16'h0: return "configure";
            16'h1: return "start";
            16'h2: return "stop";
            16'h3: return "update";
            default: return "unknown";
        endcase
    endfunction

    task automatic run_test(input int line);
        logic [15:0] op;
        logic [3:0] mask;
        int expected_writes;
        op = stim_mem[line * line_words];
        mask = stim_mem[line * line_words + 6][3:0];
        stall_enable = stim_mem[line * line_words + 7][0];
        expected_writes = 0;
        monitor.start_test($sformatf("test %0d %s", line, op_name(op)));
        period = stim_mem[line * line_words + 1];
        for (int k = 0; k < 4; k++) begin
            duty[k] = stim_mem[line * line_words + 2 + k];
        end
        case (op)
            16'h0: begin
                monitor.expect_write(base_addr, 32'h1100, 1'b0);
                monitor.expect_write(base_addr + 32'h144, 32'h1, 1'b0);
                monitor.expect_write(base_addr + 32'h13C, 32'hFF, 1'b1);
                expected_writes = 3;
                configure = 1'b1;
            end
            16'h1: begin
                monitor.expect_write(base_addr, 32'h1128, 1'b0);
                expected_writes = 1;
                model_status = 1'b1;
                start = 1'b1;
            end
            16'h2: begin
                monitor.expect_write(base_addr, 32'h1100, 1'b0);
                expected_writes = 1;
                model_status = 1'b0;
                stop = 1'b1;
                // A held update is computed from the levels present after the stop
                if (update_waiting) begin
                    expect_compare_burst(period, duty);
                    expected_writes = 10;
                    update_waiting = 1'b0;
                end
            end
            16'h3: begin
                update = mask;
                if (mask != 4'h0 && model_status) begin
                    update_waiting = 1'b1;
                end else if (mask != 4'h0) begin
                    expect_compare_burst(period, duty);
                    expected_writes = 9;
                end
            end
            default: monitor.flag_failure($sformatf("unknown operation code %h", op));
        endcase
        step_cycle();
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 4'h0;
        if (expected_writes > 0) begin
            while (monitor.pending_writes() > 0) begin
                step_cycle();
            end
            repeat (2) step_cycle();
        end else begin
            // Nothing may be written, so give the DUT time to misbehave
            repeat (20) step_cycle();
        end
        monitor.finish_test(model_status);
    endtask

    initial begin
        reset = 1'b0;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 4'h0;
        period = '0;
        duty = '0;
        foreach (stim_mem[i]) begin
            stim_mem[i] = 16'hFFFF;
        end
        $readmemh("dv/vsi_stim.txt", stim_mem);
        while (line_count < max_lines && stim_mem[line_count * line_words] != 16'hFFFF) begin
            line_count++;
        end
        cycle_limit = 100 + 120 * line_count;
        repeat (5) @(posedge clock);
        #1 reset = 1'b1;
        for (int i = 0; i < line_count; i++) begin
            run_test(i);
        end
        monitor.report_counts(DUT.protocol_chk.failure_count);
        if (line_count > 0 && monitor.error_count() == 0 && DUT.protocol_chk.failure_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            if (line_count == 0) begin
                $display("No stimulus lines could be read from dv/vsi_stim.txt");
            end
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- dv/vsi_pre_modulation_processor_chk.sv
//--------------------------------------------------
// Write bus protocol checker
// Strobe and done rules of the register write bus
//--------------------------------------------------
`timescale 1ns/1ps

module vsi_pre_modulation_processor_chk (
    input logic clock,
    input logic reset,
    input logic write_valid,
    input logic write_ready,
    input logic done
);
    int failure_count = 0;

    valid_single_cycle: assert property (@(posedge clock) disable iff (!reset)
        write_valid |=> !write_valid)
        else begin
            $error("write_valid stayed high for more than one cycle");
            failure_count++;
        end

    // The slave acknowledges by dropping ready, so a strobe needs ready high
    valid_with_ready: assert property (@(posedge clock) disable iff (!reset)
        write_valid |-> write_ready)
        else begin
            $error("write_valid raised while write_ready was low");
            failure_count++;
        end

    done_with_valid: assert property (@(posedge clock) disable iff (!reset)
        done |-> write_valid)
        else begin
            $error("done pulsed without write_valid");
            failure_count++;
        end

endmodule

bind vsi_pre_modulation_processor vsi_pre_modulation_processor_chk protocol_chk (
    .clock(clock),
    .reset(reset),
    .write_valid(write_valid),
    .write_ready(write_ready),
    .done(done)
);

//--- dv/write_monitor.sv
//--------------------------------------------------
// Write monitor
// Compares the writes, done and modulator status
// of the DUT with the expected writes in order
//--------------------------------------------------
`timescale 1ns/1ps

module write_monitor (
    input logic clock,
    input logic reset,
    input logic write_valid,
    input vsi_modulation_pkg::write_req_t write_req,
    input logic done,
    input logic modulator_status
);
    import vsi_modulation_pkg::*;

    write_req_t expected_q [$];
    logic expected_done_q [$];
    write_req_t next_expected;
    logic next_done;
    string test_name = "";
    int check_errors = 0;
    int task_errors = 0;
    int writes_seen = 0;
    int errors_before = 0;
    int writes_before = 0;
    int tests_run = 0;
    int tests_failed = 0;

    function automatic void print_mismatch(string field, logic [31:0] expected,
                                           logic [31:0] actual);
        $display("[ERROR] %s: %s expected %h, actual %h", test_name, field, expected, actual);
    endfunction

    always @(posedge clock) begin
        if (reset && done && !write_valid) begin
            $display("%s: done pulsed in a cycle without a write", test_name);
            check_errors++;
        end
        if (reset && write_valid) begin
            writes_seen++;
            if (expected_q.size() == 0) begin
                $display("%s: unexpected write of %h to %h", test_name, write_req.data,
                         write_req.dest);
                check_errors++;
            end else begin
                next_expected = expected_q.pop_front();
                next_done = expected_done_q.pop_front();
                if (write_req.dest !== next_expected.dest) begin
                    print_mismatch("address", next_expected.dest, write_req.dest);
                    check_errors++;
                end
                if (write_req.data !== next_expected.data) begin
                    print_mismatch("data", next_expected.data, write_req.data);
                    check_errors++;
                end
                if (done !== next_done) begin
                    print_mismatch("done", 32'(next_done), 32'(done));
                    check_errors++;
                end
            end
        end
    end

    task automatic start_test(input string name);
        test_name = name;
        errors_before = check_errors + task_errors;
        writes_before = writes_seen;
    endtask

    task automatic expect_write(input logic [31:0] dest, input logic [31:0] data,
                                input logic last_config);
        write_req_t req;
        req.dest = dest;
        req.data = data;
        expected_q.push_back(req);
        expected_done_q.push_back(last_config);
    endtask

    task automatic flag_failure(input string what);
        $display("%s: %s", test_name, what);
        task_errors++;
    endtask

    function automatic int pending_writes();
        return expected_q.size();
    endfunction

    function automatic int error_count();
        return check_errors + task_errors;
    endfunction

    task automatic finish_test(input logic expected_status);
        int test_errors;
        if (modulator_status !== expected_status) begin
            print_mismatch("modulator_status", 32'(expected_status), 32'(modulator_status));
            task_errors++;
        end
        test_errors = error_count() - errors_before;
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s %s (%0d writes)", test_errors == 0 ? "PASS" : "FAIL", test_name,
                 writes_seen - writes_before);
    endtask

    task automatic report_counts(input int assertion_failures);
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count(),
                 assertion_failures);
    endtask

endmodule

//--- verilog/vsi_pre_modulation_processor.sv
//--------------------------------------------------
// VSI pre-modulation processor
// Top level joining the compare calculator, the
// modulator sequencer and the register writer
//--------------------------------------------------
`timescale 1ns/1ps

module vsi_pre_modulation_processor (
    input  logic clock,
    input  logic reset,
    input  logic configure,
    input  logic start,
    input  logic stop,
    input  logic [3:0] update,
    input  logic [vsi_modulation_pkg::compare_width-1:0] period,
    input  logic [vsi_modulation_pkg::n_phases-1:0][vsi_modulation_pkg::compare_width-1:0] duty,
    input  logic write_ready,
    output logic write_valid,
    output vsi_modulation_pkg::write_req_t write_req,
    output logic done,
    output logic modulator_status
);
    import vsi_modulation_pkg::*;

    compare_set_t compare_set;
    logic compare_valid;
    writer_cmd_t command;
    logic writer_busy;

    compare_calculator calculator (
        .clock(clock),
        .reset(reset),
        .update(update),
        .period(period),
        .duty(duty),
        .modulator_status(modulator_status),
        .compare_set(compare_set),
        .compare_valid(compare_valid)
    );

    modulator_sequencer sequencer (
        .clock(clock),
        .reset(reset),
        .configure(configure),
        .start(start),
        .stop(stop),
        .writer_busy(writer_busy),
        .command(command),
        .modulator_status(modulator_status)
    );

    register_writer writer (
        .clock(clock),
        .reset(reset),
        .command(command),
        .compare_set(compare_set),
        .compare_valid(compare_valid),
        .write_ready(write_ready),
        .writer_busy(writer_busy),
        .write_valid(write_valid),
        .write_req(write_req),
        .done(done)
    );

endmodule

//--- verilog/register_writer.sv
//--------------------------------------------------
// Register writer
// Serializes control writes, the configuration
// sequence and compare bursts onto the write bus
// with a one-cycle strobe and a ready level
//--------------------------------------------------
`timescale 1ns/1ps

module register_writer (
    input  logic clock,
    input  logic reset,
    input  vsi_modulation_pkg::writer_cmd_t command,
    input  vsi_modulation_pkg::compare_set_t compare_set,
    input  logic compare_valid,
    input  logic write_ready,
    output logic writer_busy,
    output logic write_valid,
    output vsi_modulation_pkg::write_req_t write_req,
    output logic done
);
    import vsi_modulation_pkg::*;

    typedef enum logic [1:0] {st_idle, st_issue, st_wait_ack} writer_state_t;
    typedef enum logic [1:0] {job_control, job_config, job_burst} writer_job_t;

    writer_state_t state;
    writer_job_t job;
    writer_cmd_t command_slot;
    logic compare_pending;
    compare_set_t pending_set;
    compare_set_t active_set;
    logic [31:0] control_word;
    logic [3:0] word_count;
    logic [3:0] last_word;
    logic [1:0] phase_index;
    logic start_command;
    logic start_burst;
    logic send;
    write_req_t next_req;

    assign writer_busy = (state != st_idle) || (command_slot != cmd_none);

    // Commands take precedence over a waiting compare set
    assign start_command = (state == st_idle) && (command_slot != cmd_none);
    assign start_burst = (state == st_idle) && (command_slot == cmd_none) && compare_pending;
    assign send = (state == st_issue) && write_ready;

    // Address and data of the current word
    always_comb begin
        // Words 1 to 4 and 5 to 8 both map to phases 0 to 3 this way
        phase_index = word_count[1:0] - 2'd1;
        last_word = 4'd0;
        next_req.dest = pwm_base_addr + control_reg_offset;
        next_req.data = control_word;
        case (job)
            job_config: begin
                last_word = 4'(config_length - 1);
                next_req.dest = pwm_base_addr + config_sequence[word_count[1:0]].offset;
                next_req.data = config_sequence[word_count[1:0]].data;
            end
            job_burst: begin
                last_word = 4'(burst_length - 1);
                if (word_count == 4'd0) begin
                    next_req.dest = pwm_base_addr + period_reg_offset;
                    next_req.data = 32'(active_set.period);
                end else if (word_count <= 4'(n_phases)) begin
                    next_req.dest = pwm_base_addr + rise_reg_offset + 32'({phase_index, 2'b00});
                    next_req.data = 32'(active_set.rise[phase_index]);
                end else begin
                    next_req.dest = pwm_base_addr + fall_reg_offset + 32'({phase_index, 2'b00});
                    next_req.data = 32'(active_set.fall[phase_index]);
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= st_idle;
            job <= job_control;
            command_slot <= cmd_none;
            compare_pending <= 1'b0;
            word_count <= 4'd0;
            write_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            write_valid <= 1'b0;
            done <= 1'b0;
            case (state)
                st_idle: begin
                    word_count <= 4'd0;
                    if (start_command) begin
                        command_slot <= cmd_none;
                        job <= (command_slot == cmd_configure) ? job_config : job_control;
                        state <= st_issue;
                    end else if (start_burst) begin
                        compare_pending <= 1'b0;
                        job <= job_burst;
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    if (send) begin
                        write_valid <= 1'b1;
                        done <= (job == job_config) && (word_count == last_word);
                        state <= st_wait_ack;
                    end
                end
                default: begin
                    // Slave acknowledges by dropping ready, st_issue waits for it to return
                    if (!write_ready) begin
                        if (word_count == last_word) begin
                            state <= st_idle;
                        end else begin
                            word_count <= word_count + 4'd1;
                            state <= st_issue;
                        end
                    end
                end
            endcase
            if (command != cmd_none) begin
                command_slot <= command;
            end
            if (compare_valid) begin
                compare_pending <= 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clock) begin
        if (send) begin
            write_req <= next_req;
        end
        // A newer compare set replaces one that is still waiting
        if (compare_valid) begin
            pending_set <= compare_set;
        end
        if (start_burst) begin
            active_set <= pending_set;
        end
        if (start_command) begin
            control_word <= (command_slot == cmd_start) ? modulator_on_word : modulator_off_word;
        end
    end

endmodule

//--- verilog/modulator_sequencer.sv
//--------------------------------------------------
// Modulator sequencer
// Holds start, stop and configure requests until
// the register writer is free, then hands them over
// as commands and tracks the modulator state
//--------------------------------------------------
`timescale 1ns/1ps

module modulator_sequencer (
    input  logic clock,
    input  logic reset,
    input  logic configure,
    input  logic start,
    input  logic stop,
    input  logic writer_busy,
    output vsi_modulation_pkg::writer_cmd_t command,
    output logic modulator_status
);
    import vsi_modulation_pkg::*;

    logic start_request;
    logic stop_request;
    logic configure_request;
    logic issue;

    // The writer raises busy one cycle after it takes a command,
    // so a command still on the port also blocks the next one
    assign issue = !writer_busy && (command == cmd_none);

    always_ff @(posedge clock) begin
        if (!reset) begin
            start_request <= 1'b0;
            stop_request <= 1'b0;
            configure_request <= 1'b0;
            command <= cmd_none;
            modulator_status <= 1'b0;
        end else begin
            command <= cmd_none;
            start_request <= start_request | start;
            stop_request <= stop_request | stop;
            configure_request <= configure_request | configure;

            if (issue) begin
                if (stop_request) begin
                    // A stop also cancels any start that was waiting
                    command <= cmd_stop;
                    modulator_status <= 1'b0;
                    stop_request <= stop;
                    start_request <= start;
                end else if (start_request) begin
                    command <= cmd_start;
                    modulator_status <= 1'b1;
                    start_request <= start;
                end else if (configure_request) begin
                    command <= cmd_configure;
                    configure_request <= configure;
                end
            end
        end
    end

endmodule

//--- verilog/compare_calculator.sv
//--------------------------------------------------
// Compare calculator
// Collects update requests and, while the modulator
// is off, turns period and duty into center-aligned
// rising and falling compare values
//--------------------------------------------------
`timescale 1ns/1ps

module compare_calculator (
    input  logic clock,
    input  logic reset,
    input  logic [3:0] update,
    input  logic [vsi_modulation_pkg::compare_width-1:0] period,
    input  logic [vsi_modulation_pkg::n_phases-1:0][vsi_modulation_pkg::compare_width-1:0] duty,
    input  logic modulator_status,
    output vsi_modulation_pkg::compare_set_t compare_set,
    output logic compare_valid
);
    import vsi_modulation_pkg::*;

    logic update_pending;
    logic calculate;
    logic [compare_width-1:0] half_period;
    logic [n_phases-1:0][compare_width-1:0] half_duty;

    // Each half is truncated on its own, so an odd period loses its LSB
    always_comb begin
        half_period = period >> 1;
        for (int i = 0; i < n_phases; i++) begin
            half_duty[i] = duty[i] >> 1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            update_pending <= 1'b0;
            calculate <= 1'b0;
            compare_valid <= 1'b0;
        end else begin
            compare_valid <= calculate;
            if (update_pending && !modulator_status) begin
                // An update arriving right now must not be lost
                update_pending <= |update;
                calculate <= 1'b1;
            end else begin
                update_pending <= update_pending | (|update);
                calculate <= 1'b0;
            end
        end
    end

    // Values are sampled in the calculate cycle and held until the next one
    always_ff @(posedge clock) begin
        if (calculate) begin
            compare_set.period <= period;
            for (int i = 0; i < n_phases; i++) begin
                compare_set.rise[i] <= half_period - half_duty[i];
                compare_set.fall[i] <= half_period + half_duty[i];
            end
        end
    end

endmodule

//--- verilog/vsi_modulation_pkg.sv
//--------------------------------------------------
// VSI modulation package
// Register map of the PWM peripheral, the fixed
// configuration sequence and the types shared by
// the pre-modulation processor blocks
//--------------------------------------------------
package vsi_modulation_pkg;

    // Inverter geometry
    localparam int n_phases = 4;
    localparam int n_pwm_channels = 4;
    localparam int compare_width = 16;

    localparam logic [31:0] pwm_base_addr = 32'h43C0_0000;

    // Register offsets inside the PWM peripheral, one 32 bit word each
    localparam logic [31:0] control_reg_offset = 32'h0;
    localparam logic [31:0] rise_reg_offset = 32'h100;
    localparam logic [31:0] fall_reg_offset = rise_reg_offset + 4 * n_pwm_channels;
    localparam logic [31:0] period_reg_offset = rise_reg_offset + (3 * n_pwm_channels + 1) * 4;

    localparam logic [31:0] modulator_on_word = 32'h0000_1128;
    localparam logic [31:0] modulator_off_word = 32'h0000_1100;

    typedef struct packed {
        logic [31:0] offset;
        logic [31:0] data;
    } config_pair_t;

    // Configuration writes, sent in index order
    localparam int config_length = 3;
    localparam config_pair_t config_sequence [config_length] = '{
        '{offset: control_reg_offset, data: 32'h0000_1100},
        '{offset: rise_reg_offset + (3 * n_pwm_channels + 5) * 4, data: 32'h0000_0001},
        '{offset: rise_reg_offset + (3 * n_pwm_channels + 3) * 4, data: 32'h0000_00FF}
    };

    // Period word followed by one rising and one falling compare per phase
    localparam int burst_length = 1 + 2 * n_phases;

    typedef struct packed {
        logic [31:0] dest;
        logic [31:0] data;
    } write_req_t;

    typedef struct packed {
        logic [compare_width-1:0] period;
        logic [n_phases-1:0][compare_width-1:0] rise;
        logic [n_phases-1:0][compare_width-1:0] fall;
    } compare_set_t;

    typedef enum logic [1:0] {
        cmd_none,
        cmd_start,
        cmd_stop,
        cmd_configure
    } writer_cmd_t;

endpackage
